// ==== rtl/videoPkg.sv ====
/*
 * Pixel path types and the RGB332 to 24-bit color expansion.
 * Imported by the timing, object, mux and top modules.
 */
package videoPkg;

	// packed color, red 7:5, green 4:2, blue 1:0
	typedef logic [7:0] rgb332T;

	// pixel coordinate, also used for object width and height
	typedef logic [10:0] coordT;

	// one output channel
	typedef logic [7:0] channelT;

	// red, green, blue from msb down
	typedef logic [23:0] rgb888T;

	// stored bits go on top, the lowest stored bit fills the rest
	function automatic rgb888T expandColor(input rgb332T color);
		channelT red;
		channelT green;
		channelT blue;
		red = {color[7:5], {5{color[5]}}};
		green = {color[4:2], {5{color[2]}}};
		blue = {color[1:0], {6{color[0]}}};
		return {red, green, blue};
	endfunction

endpackage

// ==== rtl/regPkg.sv ====
/*
 * Register map of the object block and AXI4-Lite response codes.
 * Imported by the register slave.
 */
package regPkg;

	typedef logic [7:0] axiAddrT;
	typedef logic [31:0] axiDataT;
	typedef logic [3:0] axiStrbT;

	typedef enum logic [1:0] {
		OKAY = 2'b00,
		SLVERR = 2'b10
	} respT;

	// one group of registers per object
	localparam int OBJ_STRIDE = 16;
	localparam axiAddrT OFS_POS = 8'h00;
	localparam axiAddrT OFS_SIZE = 8'h04;
	localparam axiAddrT OFS_STYLE = 8'h08;
	localparam axiAddrT ADDR_BACKGROUND = 8'h80;

	// x and width low, y and height high
	localparam int FIELD_LO_LSB = 0;
	localparam int FIELD_HI_LSB = 16;
	localparam int COLOR_LSB = 0;
	localparam int ENABLE_BIT = 8;

endpackage

// ==== rtl/pixelIf.sv ====
/*
 * Sweep position from the timing generator to the objects and registers.
 * The timing generator drives it, everything else only listens.
 */
`timescale 1ns/100ps

interface pixelIf import videoPkg::*; ();

	coordT pixelX;
	coordT pixelY;
	// inside the visible area
	logic active;
	// single cycle, at pixel (0,0)
	logic frameStart;

	modport source (
		output pixelX,
		output pixelY,
		output active,
		output frameStart
	);

	modport sink (
		input pixelX,
		input pixelY,
		input active,
		input frameStart
	);

endinterface

// ==== rtl/vgaTiming.sv ====
/*
 * Horizontal and vertical sweep counters for the display.
 * Each line and frame starts with the visible area, then front porch,
 * sync and back porch. All outputs on pixelIf are registered.
 */
`timescale 1ns/100ps

module vgaTiming import videoPkg::*; #(
	parameter int H_ACTIVE = 640,
	parameter int H_FRONT = 16,
	parameter int H_SYNC = 96,
	parameter int H_BACK = 48,
	parameter int V_ACTIVE = 480,
	parameter int V_FRONT = 10,
	parameter int V_SYNC = 2,
	parameter int V_BACK = 33
) (
	input logic clk,
	input logic resetN,
	pixelIf.source pixel
);

	localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
	localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
	localparam coordT H_LAST = coordT'(H_TOTAL - 1);
	localparam coordT V_LAST = coordT'(V_TOTAL - 1);
	localparam coordT H_VISIBLE = coordT'(H_ACTIVE);
	localparam coordT V_VISIBLE = coordT'(V_ACTIVE);

	coordT hCount;
	coordT vCount;

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			hCount <= '0;
			vCount <= '0;
		end
		else if (hCount == H_LAST) begin
			hCount <= '0;
			// wrap at the bottom of the frame
			if (vCount == V_LAST)
				vCount <= '0;
			else
				vCount <= vCount + coordT'(1);
		end
		else begin
			hCount <= hCount + coordT'(1);
		end
	end

	// coordinates run through blanking, active marks the visible part
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			pixel.pixelX <= '0;
			pixel.pixelY <= '0;
			pixel.active <= 1'b0;
			pixel.frameStart <= 1'b0;
		end
		else begin
			pixel.pixelX <= hCount;
			pixel.pixelY <= vCount;
			pixel.active <= (hCount < H_VISIBLE) && (vCount < V_VISIBLE);
			pixel.frameStart <= (hCount == '0) && (vCount == '0);
		end
	end

endmodule

// ==== rtl/objectRegs.sv ====
/*
 * AXI4-Lite slave holding position, size, style and enable per object,
 * plus the background color. Writes land in shadow registers, which the
 * display takes over at frame start, so a frame never tears.
 */
`timescale 1ns/100ps

module objectRegs import videoPkg::*, regPkg::*; #(
	parameter int NUM_OBJECTS = 4
) (
	input logic clk,
	input logic resetN,
	input axiAddrT awaddr,
	input logic awvalid,
	output logic awready,
	input axiDataT wdata,
	input axiStrbT wstrb,
	input logic wvalid,
	output logic wready,
	output respT bresp,
	output logic bvalid,
	input logic bready,
	input axiAddrT araddr,
	input logic arvalid,
	output logic arready,
	output axiDataT rdata,
	output respT rresp,
	output logic rvalid,
	input logic rready,
	pixelIf.sink pixel,
	output coordT objX [NUM_OBJECTS],
	output coordT objY [NUM_OBJECTS],
	output coordT objW [NUM_OBJECTS],
	output coordT objH [NUM_OBJECTS],
	output rgb332T objColor [NUM_OBJECTS],
	output logic [NUM_OBJECTS-1:0] objEnable,
	output rgb332T backgroundColor
);

	typedef enum logic {WR_IDLE, WR_RESP} wrStateT;
	typedef enum logic {RD_IDLE, RD_RESP} rdStateT;

	wrStateT wrState;
	rdStateT rdState;

	// address and data may come in separate cycles
	logic awHave;
	logic wHave;
	axiAddrT awAddrQ;
	axiDataT wDataQ;
	axiStrbT wStrbQ;

	axiAddrT curAddr;
	axiDataT curData;
	axiStrbT curStrb;
	axiDataT writeImage;
	logic writeMapped;
	logic awFire;
	logic wFire;
	logic arFire;
	logic doWrite;

	coordT shX [NUM_OBJECTS];
	coordT shY [NUM_OBJECTS];
	coordT shW [NUM_OBJECTS];
	coordT shH [NUM_OBJECTS];
	rgb332T shColor [NUM_OBJECTS];
	logic [NUM_OBJECTS-1:0] shEnable;
	rgb332T shBackground;

	coordT actX [NUM_OBJECTS];
	coordT actY [NUM_OBJECTS];
	coordT actW [NUM_OBJECTS];
	coordT actH [NUM_OBJECTS];
	rgb332T actColor [NUM_OBJECTS];
	logic [NUM_OBJECTS-1:0] actEnable;
	rgb332T actBackground;

	function automatic int objIndex(input axiAddrT addr);
		return int'(addr) / OBJ_STRIDE;
	endfunction

	function automatic axiAddrT objOffset(input axiAddrT addr);
		return axiAddrT'(int'(addr) % OBJ_STRIDE);
	endfunction

	function automatic logic isMapped(input axiAddrT addr);
		return (addr == ADDR_BACKGROUND) || ((objIndex(addr) < NUM_OBJECTS) &&
			(objOffset(addr) inside {OFS_POS, OFS_SIZE, OFS_STYLE}));
	endfunction

	// shadow contents as the bus sees them
	function automatic axiDataT readImage(input axiAddrT addr);
		axiDataT img;
		int idx;
		img = '0;
		idx = objIndex(addr);
		if (addr == ADDR_BACKGROUND) begin
			img[COLOR_LSB +: $bits(rgb332T)] = shBackground;
		end
		else if (idx < NUM_OBJECTS) begin
			case (objOffset(addr))
				OFS_POS: begin
					img[FIELD_LO_LSB +: $bits(coordT)] = shX[idx];
					img[FIELD_HI_LSB +: $bits(coordT)] = shY[idx];
				end
				OFS_SIZE: begin
					img[FIELD_LO_LSB +: $bits(coordT)] = shW[idx];
					img[FIELD_HI_LSB +: $bits(coordT)] = shH[idx];
				end
				OFS_STYLE: begin
					img[COLOR_LSB +: $bits(rgb332T)] = shColor[idx];
					img[ENABLE_BIT] = shEnable[idx];
				end
				default: img = '0;
			endcase
		end
		return img;
	endfunction

	function automatic axiDataT mergeStrobe(input axiDataT oldVal, input axiDataT newVal,
			input axiStrbT strb);
		axiDataT merged;
		merged = oldVal;
		for (int b = 0; b < $bits(axiStrbT); b++) begin
			if (strb[b])
				merged[8*b +: 8] = newVal[8*b +: 8];
		end
		return merged;
	endfunction

	assign awready = (wrState == WR_IDLE) && !awHave;
	assign wready = (wrState == WR_IDLE) && !wHave;
	assign bvalid = (wrState == WR_RESP);
	assign arready = (rdState == RD_IDLE);
	assign rvalid = (rdState == RD_RESP);

	assign awFire = awvalid && awready;
	assign wFire = wvalid && wready;
	assign arFire = arvalid && arready;
	assign doWrite = (wrState == WR_IDLE) && (awHave || awFire) && (wHave || wFire);

	always_comb begin
		curAddr = awHave ? awAddrQ : awaddr;
		curData = wHave ? wDataQ : wdata;
		curStrb = wHave ? wStrbQ : wstrb;
		writeMapped = isMapped(curAddr);
		writeImage = mergeStrobe(readImage(curAddr), curData, curStrb);
	end

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			wrState <= WR_IDLE;
			rdState <= RD_IDLE;
			awHave <= 1'b0;
			wHave <= 1'b0;
			shEnable <= '0;
			shBackground <= '0;
			actEnable <= '0;
			actBackground <= '0;
			for (int i = 0; i < NUM_OBJECTS; i++) begin
				shX[i] <= '0;
				shY[i] <= '0;
				shW[i] <= '0;
				shH[i] <= '0;
				shColor[i] <= '0;
				actX[i] <= '0;
				actY[i] <= '0;
				actW[i] <= '0;
				actH[i] <= '0;
				actColor[i] <= '0;
			end
		end
		else begin
			// write channel
			if (doWrite) begin
				wrState <= WR_RESP;
				awHave <= 1'b0;
				wHave <= 1'b0;
			end
			else if (wrState == WR_RESP) begin
				if (bready)
					wrState <= WR_IDLE;
			end
			else begin
				if (awFire)
					awHave <= 1'b1;
				if (wFire)
					wHave <= 1'b1;
			end

			// unmapped writes are simply dropped
			if (doWrite && writeMapped) begin
				if (curAddr == ADDR_BACKGROUND)
					shBackground <= writeImage[COLOR_LSB +: $bits(rgb332T)];
				for (int i = 0; i < NUM_OBJECTS; i++) begin
					if (curAddr != ADDR_BACKGROUND && objIndex(curAddr) == i) begin
						case (objOffset(curAddr))
							OFS_POS: begin
								shX[i] <= writeImage[FIELD_LO_LSB +: $bits(coordT)];
								shY[i] <= writeImage[FIELD_HI_LSB +: $bits(coordT)];
							end
							OFS_SIZE: begin
								shW[i] <= writeImage[FIELD_LO_LSB +: $bits(coordT)];
								shH[i] <= writeImage[FIELD_HI_LSB +: $bits(coordT)];
							end
							default: begin
								shColor[i] <= writeImage[COLOR_LSB +: $bits(rgb332T)];
								shEnable[i] <= writeImage[ENABLE_BIT];
							end
						endcase
					end
				end
			end

			// read channel
			if (arFire)
				rdState <= RD_RESP;
			else if (rdState == RD_RESP && rready)
				rdState <= RD_IDLE;

			// snapshot for the new frame
			if (pixel.frameStart) begin
				actX <= shX;
				actY <= shY;
				actW <= shW;
				actH <= shH;
				actColor <= shColor;
				actEnable <= shEnable;
				actBackground <= shBackground;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (awFire)
			awAddrQ <= awaddr;
		if (wFire) begin
			wDataQ <= wdata;
			wStrbQ <= wstrb;
		end
		if (doWrite)
			bresp <= writeMapped ? OKAY : SLVERR;
		if (arFire) begin
			rdata <= isMapped(araddr) ? readImage(araddr) : '0;
			rresp <= isMapped(araddr) ? OKAY : SLVERR;
		end
	end

	// during the frameStart cycle the objects already evaluate pixel (0,0),
	// so they see the snapshot before it settles in the active registers
	always_comb begin
		for (int i = 0; i < NUM_OBJECTS; i++) begin
			objX[i] = pixel.frameStart ? shX[i] : actX[i];
			objY[i] = pixel.frameStart ? shY[i] : actY[i];
			objW[i] = pixel.frameStart ? shW[i] : actW[i];
			objH[i] = pixel.frameStart ? shH[i] : actH[i];
			objColor[i] = pixel.frameStart ? shColor[i] : actColor[i];
		end
		objEnable = pixel.frameStart ? shEnable : actEnable;
	end

	// the mux reads this one cycle later, after the snapshot is taken
	assign backgroundColor = actBackground;

endmodule

// ==== rtl/rectObject.sv ====
/*
 * A plain rectangle object. Raises a registered drawing request and its
 * color one cycle after the sweep enters the rectangle.
 */
`timescale 1ns/100ps

module rectObject import videoPkg::*; (
	input logic clk,
	input logic resetN,
	pixelIf.sink pixel,
	input coordT x,
	input coordT y,
	input coordT w,
	input coordT h,
	input rgb332T color,
	input logic enable,
	output logic drawRequest,
	output rgb332T rgb
);

	// one extra bit so the far edge never wraps
	logic [$bits(coordT):0] xEnd;
	logic [$bits(coordT):0] yEnd;
	logic insideX;
	logic insideY;

	assign xEnd = {1'b0, x} + {1'b0, w};
	assign yEnd = {1'b0, y} + {1'b0, h};

	// corner inclusive, corner plus size exclusive
	assign insideX = (pixel.pixelX >= x) && ({1'b0, pixel.pixelX} < xEnd);
	assign insideY = (pixel.pixelY >= y) && ({1'b0, pixel.pixelY} < yEnd);

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN)
			drawRequest <= 1'b0;
		else
			drawRequest <= enable && pixel.active && insideX && insideY;
	end

	// color travels alongside the request
	always_ff @(posedge clk) begin
		rgb <= color;
	end

endmodule

// ==== rtl/objectsMux.sv ====
/*
 * Picks the drawing object with the lowest number, or the background
 * when no object asks to draw, and expands the result to 24 bits.
 * One register stage from the requests to the RGB outputs.
 */
`timescale 1ns/100ps

module objectsMux import videoPkg::*; #(
	parameter int NUM_OBJECTS = 4
) (
	input logic clk,
	input logic resetN,
	input logic [NUM_OBJECTS-1:0] drawRequest,
	input rgb332T objectRGB [NUM_OBJECTS],
	input rgb332T backgroundColor,
	output channelT redOut,
	output channelT greenOut,
	output channelT blueOut
);

	rgb332T selectedRGB;
	rgb332T pixelRGB;
	rgb888T expanded;

	// walk from the top so object 0 has the last word
	always_comb begin
		selectedRGB = backgroundColor;
		for (int i = NUM_OBJECTS - 1; i >= 0; i--) begin
			if (drawRequest[i])
				selectedRGB = objectRGB[i];
		end
	end

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN)
			pixelRGB <= '0;
		else
			pixelRGB <= selectedRGB;
	end

	assign expanded = expandColor(pixelRGB);
	assign redOut = expanded[23:16];
	assign greenOut = expanded[15:8];
	assign blueOut = expanded[7:0];

endmodule

// ==== rtl/videoTop.sv ====
/*
 * Video compositor top. Sweep timing, AXI4-Lite object registers,
 * NUM_OBJECTS rectangles and the priority mux. Syncs, de and the
 * coordinates are delayed two cycles to line up with the color.
 */
`timescale 1ns/100ps

module videoTop import videoPkg::*; #(
	parameter int NUM_OBJECTS = 4,
	parameter int H_ACTIVE = 640,
	parameter int H_FRONT = 16,
	parameter int H_SYNC = 96,
	parameter int H_BACK = 48,
	parameter int V_ACTIVE = 480,
	parameter int V_FRONT = 10,
	parameter int V_SYNC = 2,
	parameter int V_BACK = 33
) (
	input logic clk,
	input logic resetN,
	input logic [7:0] awaddr,
	input logic awvalid,
	output logic awready,
	input logic [31:0] wdata,
	input logic [3:0] wstrb,
	input logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input logic bready,
	input logic [7:0] araddr,
	input logic arvalid,
	output logic arready,
	output logic [31:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input logic rready,
	output logic [7:0] redOut,
	output logic [7:0] greenOut,
	output logic [7:0] blueOut,
	output logic hSync,
	output logic vSync,
	output logic de,
	output coordT outX,
	output coordT outY
);

	localparam coordT H_SYNC_START = coordT'(H_ACTIVE + H_FRONT);
	localparam coordT H_SYNC_END = coordT'(H_ACTIVE + H_FRONT + H_SYNC);
	localparam coordT V_SYNC_START = coordT'(V_ACTIVE + V_FRONT);
	localparam coordT V_SYNC_END = coordT'(V_ACTIVE + V_FRONT + V_SYNC);

	pixelIf pixel ();

	coordT objX [NUM_OBJECTS];
	coordT objY [NUM_OBJECTS];
	coordT objW [NUM_OBJECTS];
	coordT objH [NUM_OBJECTS];
	rgb332T objColor [NUM_OBJECTS];
	logic [NUM_OBJECTS-1:0] objEnable;
	rgb332T backgroundColor;
	logic [NUM_OBJECTS-1:0] drawRequest;
	rgb332T objectRGB [NUM_OBJECTS];

	// two stages, index 1 is the output
	logic [1:0] hSyncPipe;
	logic [1:0] vSyncPipe;
	logic [1:0] dePipe;
	coordT xPipe [2];
	coordT yPipe [2];

	vgaTiming #(
		.H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
		.V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
	) vgaTiming_i (
		.clk(clk),
		.resetN(resetN),
		.pixel(pixel.source)
	);

	objectRegs #(.NUM_OBJECTS(NUM_OBJECTS)) objectRegs_i (
		.clk(clk), .resetN(resetN),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.pixel(pixel.sink),
		.objX(objX), .objY(objY), .objW(objW), .objH(objH),
		.objColor(objColor), .objEnable(objEnable),
		.backgroundColor(backgroundColor)
	);

	for (genvar g = 0; g < NUM_OBJECTS; g++) begin : objLoop
		rectObject rectObject_i (
			.clk(clk), .resetN(resetN),
			.pixel(pixel.sink),
			.x(objX[g]), .y(objY[g]), .w(objW[g]), .h(objH[g]),
			.color(objColor[g]), .enable(objEnable[g]),
			.drawRequest(drawRequest[g]),
			.rgb(objectRGB[g])
		);
	end

	objectsMux #(.NUM_OBJECTS(NUM_OBJECTS)) objectsMux_i (
		.clk(clk), .resetN(resetN),
		.drawRequest(drawRequest), .objectRGB(objectRGB),
		.backgroundColor(backgroundColor),
		.redOut(redOut), .greenOut(greenOut), .blueOut(blueOut)
	);

	// syncs are active low inside their porch window
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			hSyncPipe <= 2'b11;
			vSyncPipe <= 2'b11;
			dePipe <= 2'b00;
		end
		else begin
			hSyncPipe <= {hSyncPipe[0],
				!(pixel.pixelX >= H_SYNC_START && pixel.pixelX < H_SYNC_END)};
			vSyncPipe <= {vSyncPipe[0],
				!(pixel.pixelY >= V_SYNC_START && pixel.pixelY < V_SYNC_END)};
			dePipe <= {dePipe[0], pixel.active};
		end
	end

	always_ff @(posedge clk) begin
		xPipe[0] <= pixel.pixelX;
		yPipe[0] <= pixel.pixelY;
		xPipe[1] <= xPipe[0];
		yPipe[1] <= yPipe[0];
	end

	assign hSync = hSyncPipe[1];
	assign vSync = vSyncPipe[1];
	assign de = dePipe[1];
	assign outX = xPipe[1];
	assign outY = yPipe[1];

endmodule

// ==== dv/videoTop_sva.sv ====
/*
 * Concurrent checks on the AXI4-Lite responses and the video outputs.
 * Bound into videoTop, where the register slave's bus ports are visible.
 */
`timescale 1ns/100ps

module videoTop_sva (
	input logic clk,
	input logic resetN,
	input logic awready,
	input logic bvalid,
	input logic bready,
	input logic [1:0] bresp,
	input logic rvalid,
	input logic rready,
	input logic [31:0] rdata,
	input logic hSync,
	input logic vSync,
	input logic de
);

	// a response stays up and unchanged until it is taken
	bvalidHeld: assert property (@(posedge clk) disable iff (!resetN)
		bvalid && !bready |=> bvalid && $stable(bresp))
		else $error("write response dropped or changed before bready");

	rvalidHeld: assert property (@(posedge clk) disable iff (!resetN)
		rvalid && !rready |=> rvalid && $stable(rdata))
		else $error("read response dropped or changed before rready");

	// no new write address while a response waits
	awreadyStalled: assert property (@(posedge clk) disable iff (!resetN)
		bvalid |-> !awready)
		else $error("awready high while a write response waits");

	// syncs belong to blanking only
	syncsIdle: assert property (@(posedge clk) disable iff (!resetN)
		de |-> hSync && vSync)
		else $error("sync pulse while de is high");

endmodule

bind videoTop videoTop_sva videoTop_sva_i (
	.clk(clk), .resetN(resetN),
	.awready(awready),
	.bvalid(bvalid), .bready(bready), .bresp(bresp),
	.rvalid(rvalid), .rready(rready), .rdata(rdata),
	.hSync(hSync), .vSync(vSync), .de(de)
);

// ==== dv/videoTop_tb.sv ====
/*
 * Testbench for the video compositor. Places objects over AXI4-Lite,
 * mirrors the shadow and committed registers, and checks every visible
 * pixel against a reference model on a small 16x12 screen.
 */
`timescale 1ns/100ps

module videoTop_tb;

	localparam int NUM_OBJECTS = 4;
	localparam int H_ACTIVE = 16;
	localparam int H_FRONT = 2;
	localparam int H_SYNC = 3;
	localparam int H_BACK = 3;
	localparam int V_ACTIVE = 12;
	localparam int V_FRONT = 1;
	localparam int V_SYNC = 2;
	localparam int V_BACK = 1;
	// sync pulses follow the front porch
	localparam int H_SYNC_START = H_ACTIVE + H_FRONT;
	localparam int H_SYNC_END = H_SYNC_START + H_SYNC;
	localparam int V_SYNC_START = V_ACTIVE + V_FRONT;
	localparam int V_SYNC_END = V_SYNC_START + V_SYNC;
	localparam int CLK_PERIOD = 20;
	localparam int FRAME_CYCLES = (H_ACTIVE + H_FRONT + H_SYNC + H_BACK) *
		(V_ACTIVE + V_FRONT + V_SYNC + V_BACK);
	// frames waited by the stimulus below
	localparam int TEST_FRAMES = 12;
	// reset, bus traffic and a spare frame on top
	localparam int WATCHDOG_NS = (TEST_FRAMES + 3) * FRAME_CYCLES * CLK_PERIOD;
	// three registers per object, then the background
	localparam int SLOTS = 3 * NUM_OBJECTS + 1;
	localparam int BG_SLOT = 3 * NUM_OBJECTS;

	logic clk;
	logic resetN;
	logic [7:0] awaddr, araddr;
	logic [31:0] wdata, rdata;
	logic [3:0] wstrb;
	logic awvalid, awready, wvalid, wready, bvalid, bready;
	logic arvalid, arready, rvalid, rready;
	logic [1:0] bresp, rresp;
	logic [7:0] redOut, greenOut, blueOut;
	logic hSync, vSync, de;
	logic [10:0] outX, outY;

	int pixelErrors;
	int syncErrors;
	int busErrors;
	int pixelsChecked;
	int frameCount;
	logic [31:0] lfsr;
	logic [31:0] shadowModel [SLOTS];
	logic [31:0] committed [SLOTS];
	// shadow as seen one and two cycles back
	logic [31:0] histA [SLOTS];
	logic [31:0] histB [SLOTS];
	int pendSlot;
	logic [31:0] pendData;
	logic [3:0] pendStrb;
	logic bvalidSeen;

	videoTop #(
		.NUM_OBJECTS(NUM_OBJECTS),
		.H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
		.V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
	) videoTop_i (.*);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// Galois LFSR, one step per bit taken
	function automatic logic [31:0] randBits(input int count);
		logic [31:0] value;
		logic lsb;
		value = '0;
		for (int i = 0; i < count; i++) begin
			lsb = lfsr[0];
			lfsr = lfsr >> 1;
			if (lsb)
				lfsr = lfsr ^ 32'h80200003;
			value = {value[30:0], lsb};
		end
		return value;
	endfunction

	// register slot of a byte address, -1 when unmapped
	function automatic int slotOf(input logic [7:0] addr);
		if (addr == 8'h80)
			return BG_SLOT;
		if (int'(addr[7:4]) < NUM_OBJECTS && addr[1:0] == 2'b00 && addr[3:2] != 2'b11)
			return int'(addr[7:4]) * 3 + int'(addr[3:2]);
		return -1;
	endfunction

	function automatic logic [31:0] fieldMask(input int slot);
		if (slot == BG_SLOT)
			return 32'h0000_00FF;
		if (slot % 3 == 2)
			return 32'h0000_01FF;
		return 32'h07FF_07FF;
	endfunction

	function automatic void applyWrite(input int slot, input logic [31:0] data,
			input logic [3:0] strb);
		for (int b = 0; b < 4; b++) begin
			if (strb[b])
				shadowModel[slot][8*b +: 8] = data[8*b +: 8];
		end
		shadowModel[slot] = shadowModel[slot] & fieldMask(slot);
	endfunction

	// stored bits on top, lowest stored bit repeated below
	function automatic logic [23:0] expand332(input logic [7:0] c);
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
		r = {8{c[5]}};
		r[7:5] = c[7:5];
		g = {8{c[2]}};
		g[7:5] = c[4:2];
		b = {8{c[0]}};
		b[7:6] = c[1:0];
		return {r, g, b};
	endfunction

	// expected pixel from the committed registers, object 0 first
	function automatic logic [23:0] refPixel(input int x, input int y);
		logic [7:0] color;
		logic found;
		int ox, oy, ow, oh;
		color = committed[BG_SLOT][7:0];
		found = 1'b0;
		for (int i = 0; i < NUM_OBJECTS; i++) begin
			ox = int'(committed[3*i][10:0]);
			oy = int'(committed[3*i][26:16]);
			ow = int'(committed[3*i+1][10:0]);
			oh = int'(committed[3*i+1][26:16]);
			if (!found && committed[3*i+2][8] && x >= ox && x < ox + ow &&
					y >= oy && y < oy + oh) begin
				color = committed[3*i+2][7:0];
				found = 1'b1;
			end
		end
		return expand332(color);
	endfunction

	// compares every visible pixel and tracks the frame commit
	always @(negedge clk) begin : monitor
		logic [23:0] expected;
		logic expHSync;
		logic expVSync;
		logic expDe;
		if (resetN) begin
			if (bvalid && !bvalidSeen && pendSlot >= 0)
				applyWrite(pendSlot, pendData, pendStrb);
			bvalidSeen = bvalid;
			// (0,0) on the output left pixelIf two cycles ago
			if (de && outX == 0 && outY == 0) begin
				committed = histB;
				frameCount++;
			end
			if (de) begin
				expected = refPixel(int'(outX), int'(outY));
				pixelsChecked++;
				assert ({redOut, greenOut, blueOut} == expected) else begin
					pixelErrors++;
					$display("FAILED %0t: pixel (%0d,%0d) is %h, expected %h", $time,
						outX, outY, {redOut, greenOut, blueOut}, expected);
				end
			end
			// syncs and de against the coordinate they travel with
			if (frameCount > 0) begin
				expHSync = !(outX >= H_SYNC_START && outX < H_SYNC_END);
				expVSync = !(outY >= V_SYNC_START && outY < V_SYNC_END);
				expDe = (outX < H_ACTIVE) && (outY < V_ACTIVE);
				assert (hSync == expHSync && vSync == expVSync && de == expDe) else begin
					syncErrors++;
					$display("FAILED %0t: at (%0d,%0d) hSync/vSync/de are %b%b%b, expected %b%b%b",
						$time, outX, outY, hSync, vSync, de, expHSync, expVSync, expDe);
				end
			end
			histB = histA;
			histA = shadowModel;
		end
	end

	task automatic axiWrite(input logic [7:0] addr, input logic [31:0] data,
			input logic [3:0] strb);
		int slot;
		logic awGo, wGo, lateData;
		logic [1:0] expResp;
		slot = slotOf(addr);
		expResp = (slot >= 0) ? 2'b00 : 2'b10;
		pendSlot = slot;
		pendData = data;
		pendStrb = strb;
		@(negedge clk);
		awaddr = addr;
		wdata = data;
		wstrb = strb;
		awvalid = 1'b1;
		// data sometimes follows the address a cycle later
		lateData = randBits(1) != 0;
		wvalid = !lateData;
		while (awvalid || wvalid || lateData) begin
			awGo = awvalid && awready;
			wGo = wvalid && wready;
			@(negedge clk);
			if (awGo)
				awvalid = 1'b0;
			if (wGo)
				wvalid = 1'b0;
			if (lateData) begin
				wvalid = 1'b1;
				lateData = 1'b0;
			end
		end
		repeat (int'(randBits(2))) @(negedge clk);
		bready = 1'b1;
		while (!bvalid)
			@(negedge clk);
		assert (bresp == expResp) else begin
			busErrors++;
			$display("FAILED %0t: write to %h answered %b, expected %b", $time, addr,
				bresp, expResp);
		end
		@(negedge clk);
		bready = 1'b0;
	endtask

	task automatic axiRead(input logic [7:0] addr);
		int slot;
		logic [31:0] expData;
		logic [1:0] expResp;
		slot = slotOf(addr);
		expData = (slot >= 0) ? shadowModel[slot] : 32'h0;
		expResp = (slot >= 0) ? 2'b00 : 2'b10;
		@(negedge clk);
		araddr = addr;
		arvalid = 1'b1;
		while (!arready)
			@(negedge clk);
		@(negedge clk);
		arvalid = 1'b0;
		repeat (int'(randBits(2))) @(negedge clk);
		rready = 1'b1;
		while (!rvalid)
			@(negedge clk);
		assert (rdata == expData && rresp == expResp) else begin
			busErrors++;
			$display("FAILED %0t: read of %h gave %h/%b, expected %h/%b", $time, addr,
				rdata, rresp, expData, expResp);
		end
		@(negedge clk);
		rready = 1'b0;
	endtask

	task automatic placeObject(input int idx, input int x, input int y, input int w,
			input int h, input logic [7:0] color);
		logic [7:0] base;
		base = 8'(idx * 16);
		axiWrite(base, {5'b0, 11'(y), 5'b0, 11'(x)}, 4'hF);
		axiWrite(base + 8'h04, {5'b0, 11'(h), 5'b0, 11'(w)}, 4'hF);
		axiWrite(base + 8'h08, {23'b0, 1'b1, color}, 4'hF);
	endtask

	task automatic waitFrames(input int count);
		int target;
		target = frameCount + count;
		wait (frameCount >= target);
	endtask

	initial begin : stimulus
		int x1, y1;
		lfsr = 32'h26edbd1c;
		{awaddr, araddr, wdata, wstrb} = '0;
		{awvalid, wvalid, bready, arvalid, rready} = '0;
		pixelErrors = 0;
		syncErrors = 0;
		busErrors = 0;
		pixelsChecked = 0;
		frameCount = 0;
		pendSlot = -1;
		pendData = '0;
		pendStrb = '0;
		bvalidSeen = 1'b0;
		for (int s = 0; s < SLOTS; s++) begin
			shadowModel[s] = '0;
			committed[s] = '0;
			histA[s] = '0;
			histB[s] = '0;
		end
		resetN = 1'b0;
		repeat (2) @(negedge clk);
		resetN = 1'b1;

		// background only, changed once at a frame boundary
		axiWrite(8'h80, randBits(8), 4'b0001);
		waitFrames(2);
		axiWrite(8'h80, randBits(8), 4'b0001);
		waitFrames(2);

		// one object, edges included
		x1 = int'(randBits(4));
		y1 = int'(randBits(4)) % V_ACTIVE;
		placeObject(1, x1, y1, 2 + int'(randBits(3)), 2 + int'(randBits(3)),
			8'(randBits(8)));
		waitFrames(2);

		// overlapping objects, then object 0 turned off by its enable byte only
		placeObject(0, x1 + 1, y1 + 1, 2 + int'(randBits(3)), 2 + int'(randBits(3)),
			8'(randBits(8)));
		placeObject(2, x1, y1, 3 + int'(randBits(3)), 3 + int'(randBits(3)),
			8'(randBits(8)));
		waitFrames(2);
		axiWrite(8'h08, 32'h0, 4'b0010);
		waitFrames(2);

		// writes in the middle of a frame wait for the next one
		wait (de && outY == 6);
		axiWrite(8'h80, randBits(8), 4'b0001);
		placeObject(3, int'(randBits(4)), int'(randBits(3)), 4, 4, 8'(randBits(8)));
		waitFrames(2);

		// read back, partial strobes and unmapped addresses
		for (int i = 0; i < NUM_OBJECTS; i++) begin
			for (int ofs = 0; ofs < 12; ofs += 4)
				axiRead(8'(i * 16 + ofs));
		end
		axiRead(8'h80);
		axiWrite(8'h34, randBits(32), 4'b0101);
		axiRead(8'h34);
		axiWrite(8'h0C, 32'hFFFF_FFFF, 4'hF);
		axiRead(8'h0C);
		axiRead(8'h84);
		axiRead(8'h40);
		axiRead(8'h08);

		assert (pixelsChecked > 0) else begin
			pixelErrors++;
			$display("no visible pixel was ever checked");
		end
		$display("errors: pixel %0d, sync %0d, bus %0d (pixels checked %0d)", pixelErrors,
			syncErrors, busErrors, pixelsChecked);
		if (pixelErrors == 0 && syncErrors == 0 && busErrors == 0) begin
			$display("TESTS PASSED");
		end
		else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

	initial begin : watchdog
		#(WATCHDOG_NS);
		$display("watchdog timeout: the run did not finish within %0d ns", WATCHDOG_NS);
		$display("TESTS FAILED");
		$finish;
	end

endmodule

// ==== compile.f ====
rtl/videoPkg.sv
rtl/regPkg.sv
rtl/pixelIf.sv
rtl/vgaTiming.sv
rtl/objectRegs.sv
rtl/rectObject.sv
rtl/objectsMux.sv
rtl/videoTop.sv
dv/videoTop_sva.sv
dv/videoTop_tb.sv

// ==== Makefile ====
# Verilator build and run of the video compositor testbench

VERILATOR ?= verilator
VFLAGS = --binary --timing --assert -Wno-fatal
TOP = videoTop_tb
FILELIST = compile.f
OBJDIR = obj_dir
SIM = $(OBJDIR)/V$(TOP)
SOURCES = $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf $(OBJDIR)
